/* data_source_top.f */
logic/source_pkg.sv
logic/cmd_regs.sv
logic/cmd_sequencer.sv
logic/byte_ram.sv
logic/dump_streamer.sv
logic/data_source_top.sv
tests/tb_clock.sv
tests/data_source_sva.sv
tests/tb_data_source.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_data_source -f data_source_top.f -o tb_data_source
if [ $? -ne 0 ]; then
  echo "verilator build error"
  exit 1
fi

sim_out=$(./obj_dir/tb_data_source +verilator+error+limit+100)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1

/* tests/tb_data_source.sv */
`timescale 1ns/1ps

module tb_data_source;
  import source_pkg::*;

  localparam int CLK_NS      = 8;
  localparam int NUM_PAIRS   = 20;
  // two dumps at up to 2 cycles per beat plus one more dump as margin
  localparam int WDOG_CYCLES = 3 * 2 * RAM_DEPTH + 500;

  logic                  clk;
  logic                  rst;
  logic [CSR_ADDR_W-1:0] avs_address;
  logic                  avs_chipselect;
  logic                  avs_write_n;
  logic [CSR_W-1:0]      avs_writedata;
  logic [CSR_W-1:0]      avs_readdata;
  logic [BYTE_W-1:0]     axis4_m_tdata;
  logic                  axis4_m_tvalid;
  logic                  axis4_m_tlast;
  logic                  axis4_m_tready;
  logic                  dma_ack;
  logic                  dma_req;

  logic [BYTE_W-1:0]     model_mem [RAM_DEPTH];
  bit                    model_set [RAM_DEPTH];
  logic [RAM_ADDR_W-1:0] used_addr [NUM_PAIRS];
  int                    err_count  = 0;
  int                    chk_count  = 0;
  int                    mon_errors = 0;
  int                    mon_checks = 0;
  int                    mon_beats  = 0;
  int                    mon_lasts  = 0;
  int unsigned           seed_val;

  tb_clock u_tb_clock (.clk, .rst);

  data_source_top u_data_source_top (
    .clk, .rst,
    .avs_address, .avs_chipselect, .avs_write_n, .avs_writedata, .avs_readdata,
    .axis4_m_tdata, .axis4_m_tvalid, .axis4_m_tlast, .axis4_m_tready,
    .dma_ack, .dma_req
  );

  bind data_source_top data_source_sva u_data_source_sva (
    .clk (clk), .rst (rst),
    .avs_address (avs_address), .avs_chipselect (avs_chipselect),
    .avs_write_n (avs_write_n),
    .axis4_m_tdata (axis4_m_tdata), .axis4_m_tvalid (axis4_m_tvalid),
    .axis4_m_tlast (axis4_m_tlast), .axis4_m_tready (axis4_m_tready),
    .dma_ack (dma_ack), .dma_req (dma_req)
  );

  function automatic logic [31:0] make_cmd(input logic [1:0] kind,
                                           input logic [11:0] addr,
                                           input logic [7:0] data);
    return {8'h00, data, addr, 1'b0, kind, 1'b1};  // data in 23:16 and addr in 15:4
  endfunction

  function automatic int errors_so_far();
    return err_count + mon_errors + u_data_source_top.u_data_source_sva.fail_total;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    chk_count++;
    assert (got === exp) else begin
      $display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic avs_write(input logic [1:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    avs_address    = addr;
    avs_writedata  = data;
    avs_chipselect = 1'b1;
    avs_write_n    = 1'b0;
    @(posedge clk);  // register takes the write here
    #1;
    avs_chipselect = 1'b0;
    avs_write_n    = 1'b1;
  endtask

  task automatic avs_read(input logic [1:0] addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    avs_address    = addr;
    avs_chipselect = 1'b1;
    avs_write_n    = 1'b1;
    #2 data = avs_readdata;  // readdata follows address combinationally
  endtask

  // poll one register bit until it drops
  task automatic wait_bit_low(input logic [1:0] addr, input int bit_idx, input int limit);
    logic [31:0] rd;
    int          n;
    n = 0;
    do begin
      avs_read(addr, rd);
      n++;
    end while (rd[bit_idx] && n < limit);
    assert (!rd[bit_idx]) else begin
      $display("register %0d bit %0d still set after %0d polls", addr, bit_idx, limit);
      err_count++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int base);
    $display("test %0d %s: %0d errors", num, name, errors_so_far() - base);
  endtask

  initial begin : watchdog
    #(WDOG_CYCLES * CLK_NS);
    $display("watchdog expired after %0d cycles, run stopped", WDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin : tready_driver
    axis4_m_tready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (!rst)
        axis4_m_tready = ($urandom % 4) != 0;  // roughly 75% ready
    end
  end

  // accepted beats seen at the falling edge
  initial begin : beat_monitor
    logic [RAM_ADDR_W-1:0] dump_addr;
    dump_addr = '0;
    forever begin
      @(negedge clk);
      if (axis4_m_tvalid && axis4_m_tready) begin
        mon_checks++;
        assert (axis4_m_tlast === (dump_addr == 12'd4095)) else begin
          $display("ERR %0t axis4_m_tlast: got %b expected %b", $time,
                   axis4_m_tlast, dump_addr == 12'd4095);
          mon_errors++;
        end
        if (model_set[dump_addr]) begin
          mon_checks++;
          assert (axis4_m_tdata === model_mem[dump_addr]) else begin
            $display("ERR %0t axis4_m_tdata: got %h expected %h", $time,
                     axis4_m_tdata, model_mem[dump_addr]);
            mon_errors++;
          end
        end
        if (axis4_m_tlast)
          mon_lasts++;
        mon_beats++;
        dump_addr++;  // wraps to 0 for the next dump
      end
    end
  end

  initial begin : main_seq
    logic [31:0]           rd;
    logic [RAM_ADDR_W-1:0] addr;
    logic [BYTE_W-1:0]     data;
    int                    base;
    int                    beats0;
    int                    lasts0;
    int                    total;
    avs_address    = '0;
    avs_chipselect = 1'b0;
    avs_write_n    = 1'b1;
    avs_writedata  = '0;
    dma_ack        = 1'b0;
    seed_val = $urandom(32'h7984_c729);
    wait (rst === 1'b0);

    base = errors_so_far();
    for (int i = 0; i < 4; i++) begin
      avs_read(2'(i), rd);
      check_eq($sformatf("register %0d readdata", i), rd, 32'd0);
    end
    check_eq("axis4_m_tvalid", 32'(axis4_m_tvalid), 32'd0);
    check_eq("dma_req", 32'(dma_req), 32'd0);
    report_test(1, "reset values", base);

    base = errors_so_far();
    for (int i = 0; i < NUM_PAIRS; i++) begin
      addr = 12'($urandom);
      data = 8'($urandom);
      used_addr[i]    = addr;
      model_mem[addr] = data;
      model_set[addr] = 1'b1;
      avs_write(REG_CTRL, make_cmd(CMD_WRITE, addr, data));
      wait_bit_low(REG_STAT, 0, 50);
      avs_write(REG_CTRL, make_cmd(CMD_READ, addr, 8'h00));
      wait_bit_low(REG_STAT, 0, 50);
      avs_read(REG_CTRL, rd);
      check_eq("ctrl valid bit", 32'(rd[0]), 32'd0);
      avs_read(REG_STAT, rd);
      check_eq("stat read byte", 32'(rd[15:8]), 32'(model_mem[addr]));
      avs_read(REG_DBG, rd);
      check_eq("dbg address", 32'(rd[27:16]), 32'(addr));
    end
    report_test(2, "write and read commands", base);

    base   = errors_so_far();
    beats0 = mon_beats;
    lasts0 = mon_lasts;
    avs_write(REG_CTRL, make_cmd(CMD_DUMP, 12'h000, 8'h00));
    wait_bit_low(REG_STAT, 0, 4 * RAM_DEPTH);
    check_eq("dump beat total", 32'(mon_beats - beats0), 32'(RAM_DEPTH));
    check_eq("dump tlast total", 32'(mon_lasts - lasts0), 32'd1);
    avs_read(REG_STAT, rd);
    check_eq("stat busy bit", 32'(rd[0]), 32'd0);
    report_test(3, "dump under back-pressure", base);

    base = errors_so_far();
    avs_read(REG_DBG, rd);
    check_eq("dbg beat count", 32'(rd[15:0]), 32'(RAM_DEPTH));
    check_eq("dbg state", 32'(rd[29:28]), 32'd0);
    avs_write(REG_CTRL, 32'h8000_0000);
    avs_read(REG_DBG, rd);
    check_eq("dbg beat count", 32'(rd[15:0]), 32'd0);
    avs_read(REG_CTRL, rd);
    check_eq("ctrl clear bit", 32'(rd[31]), 32'd0);
    report_test(4, "debug register", base);

    base = errors_so_far();
    avs_write(REG_DMA, 32'h0000_0001);
    check_eq("dma_req", 32'(dma_req), 32'd1);
    @(posedge clk);
    #1 dma_ack = 1'b1;
    @(posedge clk);
    #1 dma_ack = 1'b0;
    check_eq("dma_req", 32'(dma_req), 32'd0);
    report_test(5, "dma request", base);

    // read command parked in CTRL behind a dump
    base   = errors_so_far();
    beats0 = mon_beats;
    lasts0 = mon_lasts;
    addr   = used_addr[0];
    avs_write(REG_CTRL, make_cmd(CMD_DUMP, 12'h000, 8'h00));
    avs_read(REG_STAT, rd);
    check_eq("stat busy bit", 32'(rd[0]), 32'd1);
    avs_read(REG_DBG, rd);
    check_eq("dbg state", 32'(rd[29:28]), 32'd2);
    avs_write(REG_CTRL, make_cmd(CMD_READ, addr, 8'h00));
    avs_read(REG_CTRL, rd);
    check_eq("ctrl valid bit", 32'(rd[0]), 32'd1);
    wait_bit_low(REG_CTRL, 0, 4 * RAM_DEPTH);
    wait_bit_low(REG_STAT, 0, 50);
    avs_read(REG_STAT, rd);
    check_eq("stat read byte", 32'(rd[15:8]), 32'(model_mem[addr]));
    check_eq("dump beat total", 32'(mon_beats - beats0), 32'(RAM_DEPTH));
    check_eq("dump tlast total", 32'(mon_lasts - lasts0), 32'd1);
    report_test(6, "command while busy", base);

    total = errors_so_far();
    $display("tests: 6, checks: %0d, errors: %0d", chk_count + mon_checks, total);
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* tests/data_source_sva.sv */
`timescale 1ns/1ps

module data_source_sva (
  input logic                               clk,
  input logic                               rst,
  input logic [source_pkg::CSR_ADDR_W-1:0]  avs_address,
  input logic                               avs_chipselect,
  input logic                               avs_write_n,
  input logic [source_pkg::BYTE_W-1:0]      axis4_m_tdata,
  input logic                               axis4_m_tvalid,
  input logic                               axis4_m_tlast,
  input logic                               axis4_m_tready,
  input logic                               dma_ack,
  input logic                               dma_req
);
  import source_pkg::*;

  int   reset_fails = 0;
  int   tlast_fails = 0;
  int   hold_fails  = 0;
  int   dma_fails   = 0;
  int   fail_total;
  logic dma_write;

  assign dma_write  = avs_chipselect && !avs_write_n && (avs_address == REG_DMA);
  assign fail_total = reset_fails + tlast_fails + hold_fails + dma_fails;

  reset_quiet: assert property (@(posedge clk)
    rst |-> !axis4_m_tvalid && !axis4_m_tlast && !dma_req)
    else begin
      $error("stream or dma_req active during reset");
      reset_fails++;
    end

  tlast_needs_valid: assert property (@(posedge clk) disable iff (rst)
    axis4_m_tlast |-> axis4_m_tvalid)
    else begin
      $error("tlast high without tvalid");
      tlast_fails++;
    end

  // stalled beat must not change
  hold_on_stall: assert property (@(posedge clk) disable iff (rst)
    axis4_m_tvalid && !axis4_m_tready |=>
      axis4_m_tvalid && $stable(axis4_m_tdata) && $stable(axis4_m_tlast))
    else begin
      $error("stream beat changed while stalled");
      hold_fails++;
    end

  dma_ack_clears: assert property (@(posedge clk) disable iff (rst)
    dma_ack && !dma_write |=> !dma_req)
    else begin
      $error("dma_req still high after dma_ack");
      dma_fails++;
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);
  localparam int HALF_NS = 4;  // 8 ns period

  initial begin
    clk = 1'b0;
    forever #HALF_NS clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

/* logic/data_source_top.sv */
`timescale 1ns/1ps

module data_source_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [source_pkg::CSR_ADDR_W-1:0]   avs_address,
  input  logic                                avs_chipselect,
  input  logic                                avs_write_n,
  input  logic [source_pkg::CSR_W-1:0]        avs_writedata,
  output logic [source_pkg::CSR_W-1:0]        avs_readdata,
  output logic [source_pkg::BYTE_W-1:0]       axis4_m_tdata,
  output logic                                axis4_m_tvalid,
  output logic                                axis4_m_tlast,
  input  logic                                axis4_m_tready,
  input  logic                                dma_ack,
  output logic                                dma_req
);
  import source_pkg::*;

  avs_req_t              avs_req;
  cmd_t                  cmd;
  ram_req_t              ram_req;
  ram_rsp_t              ram_rsp;
  axis_t                 axis;
  seq_state_e            seq_state;
  logic                  cmd_accept;
  logic                  beat_taken;
  logic [BYTE_W-1:0]     rd_byte;
  logic                  rd_byte_load;
  logic                  busy;
  logic [RAM_ADDR_W-1:0] cur_addr;
  logic [CNT_W-1:0]      beat_count;
  logic                  clear_cnt;

  assign avs_req = '{chipselect: avs_chipselect, write_n: avs_write_n,
                     address: avs_address, writedata: avs_writedata};

  cmd_regs u_cmd_regs (
    .clk, .rst,
    .avs (avs_req), .readdata (avs_readdata),
    .cmd, .cmd_accept,
    .rd_byte, .rd_byte_load, .busy,
    .seq_state, .cur_addr, .beat_count,
    .clear_cnt, .dma_ack, .dma_req
  );

  cmd_sequencer u_cmd_sequencer (
    .clk, .rst,
    .cmd, .cmd_accept,
    .ram_req, .ram_rsp, .beat_taken,
    .rd_byte, .rd_byte_load, .busy,
    .seq_state, .cur_addr
  );

  byte_ram u_byte_ram (
    .clk, .ram_req, .ram_rsp
  );

  dump_streamer u_dump_streamer (
    .clk, .rst,
    .ram_rsp, .axis, .tready (axis4_m_tready),
    .beat_taken, .clear_cnt, .beat_count
  );

  assign axis4_m_tdata  = axis.tdata;
  assign axis4_m_tvalid = axis.tvalid;
  assign axis4_m_tlast  = axis.tlast;

endmodule

/* logic/dump_streamer.sv */
`timescale 1ns/1ps

module dump_streamer (
  input  logic                          clk,
  input  logic                          rst,
  input  source_pkg::ram_rsp_t          ram_rsp,
  output source_pkg::axis_t             axis,
  input  logic                          tready,
  output logic                          beat_taken,
  input  logic                          clear_cnt,
  output logic [source_pkg::CNT_W-1:0]  beat_count
);
  import source_pkg::*;

  logic [BYTE_W-1:0]     buf_data [DUMP_FIFO_DEPTH];
  logic                  buf_last [DUMP_FIFO_DEPTH];
  logic [DUMP_PTR_W-1:0] wr_ptr;
  logic [DUMP_PTR_W-1:0] rd_ptr;
  logic [DUMP_PTR_W:0]   count;
  logic                  push;
  logic                  out_valid;

  // only dump reads enter the buffer, credits keep it from overflowing
  assign push       = ram_rsp.valid && ram_rsp.dump;
  assign out_valid  = (count != '0);
  assign beat_taken = out_valid && tready;

  always_ff @(posedge clk) begin
    if (push) begin
      buf_data[wr_ptr] <= ram_rsp.data;
      buf_last[wr_ptr] <= ram_rsp.last;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (beat_taken)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !beat_taken)
        count <= count + 1'b1;
      else if (!push && beat_taken)
        count <= count - 1'b1;
    end
  end

  // head entry stays put until taken
  always_comb begin
    axis.tdata  = buf_data[rd_ptr];
    axis.tvalid = out_valid;
    axis.tlast  = out_valid && buf_last[rd_ptr];
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      beat_count <= '0;
    else if (clear_cnt)
      beat_count <= '0;
    else if (beat_taken)
      beat_count <= beat_count + 1'b1;  // wraps past 65535
  end

endmodule

/* logic/byte_ram.sv */
`timescale 1ns/1ps

module byte_ram (
  input  logic                 clk,
  input  source_pkg::ram_req_t ram_req,
  output source_pkg::ram_rsp_t ram_rsp
);
  import source_pkg::*;

  logic [BYTE_W-1:0] mem [RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (ram_req.wr)
      mem[ram_req.addr] <= ram_req.wdata;
  end

  // registered read, tags travel alongside the data
  always_ff @(posedge clk) begin
    ram_rsp.valid <= ram_req.rd;
    ram_rsp.dump  <= ram_req.dump;
    ram_rsp.last  <= ram_req.last;
    if (ram_req.rd)
      ram_rsp.data <= mem[ram_req.addr];
  end

endmodule

/* logic/cmd_sequencer.sv */
`timescale 1ns/1ps

module cmd_sequencer (
  input  logic                                clk,
  input  logic                                rst,
  input  source_pkg::cmd_t                    cmd,
  output logic                                cmd_accept,
  output source_pkg::ram_req_t                ram_req,
  input  source_pkg::ram_rsp_t                ram_rsp,
  input  logic                                beat_taken,
  output logic [source_pkg::BYTE_W-1:0]       rd_byte,
  output logic                                rd_byte_load,
  output logic                                busy,
  output source_pkg::seq_state_e              seq_state,
  output logic [source_pkg::RAM_ADDR_W-1:0]   cur_addr
);
  import source_pkg::*;

  seq_state_e            state;
  logic [DUMP_PTR_W:0]   credits;     // free slots in the streamer buffer
  logic                  issue_done;  // last dump address already issued
  logic                  dump_issue;
  logic                  dump_last;
  logic                  dump_done;

  // new commands only once the previous one has fully retired
  assign cmd_accept = (state == IDLE) && !busy && cmd.valid;

  assign dump_issue = (state == DUMP) && !issue_done && (credits != '0);
  assign dump_last  = (cur_addr == RAM_ADDR_W'(RAM_DEPTH - 1));

  // last outstanding beat leaves the streamer
  assign dump_done = issue_done && beat_taken &&
                     (credits == (DUMP_PTR_W + 1)'(DUMP_FIFO_DEPTH - 1));

  assign rd_byte      = ram_rsp.data;
  assign rd_byte_load = (state == READ_WAIT) && ram_rsp.valid && !ram_rsp.dump;
  assign seq_state    = state;

  always_comb begin
    ram_req       = '0;
    ram_req.addr  = cmd.addr;
    ram_req.wdata = cmd.data;
    if (cmd_accept) begin
      ram_req.wr = (cmd.cmd_type == CMD_WRITE);
      ram_req.rd = (cmd.cmd_type == CMD_READ);
    end
    if (dump_issue) begin
      ram_req.rd   = 1'b1;
      ram_req.dump = 1'b1;
      ram_req.last = dump_last;
      ram_req.addr = cur_addr;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      credits <= (DUMP_PTR_W + 1)'(DUMP_FIFO_DEPTH);
    end else begin
      case ({dump_issue, beat_taken})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= IDLE;
      busy       <= 1'b0;
      cur_addr   <= '0;
      issue_done <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (cmd_accept) begin
            busy     <= 1'b1;
            cur_addr <= cmd.addr;
            case (cmd.cmd_type)
              CMD_READ: state <= READ_WAIT;
              CMD_DUMP: begin
                state      <= DUMP;
                cur_addr   <= '0;
                issue_done <= 1'b0;
              end
              CMD_WRITE, CMD_RSVD: begin
                // write goes out on ram_req this cycle, rsvd is dropped
              end
              default: state <= IDLE;
            endcase
          end else if (busy) begin
            busy <= 1'b0;  // single-cycle commands retire here
          end
        end
        READ_WAIT: begin
          if (rd_byte_load) begin
            busy  <= 1'b0;
            state <= IDLE;
          end
        end
        DUMP: begin
          if (dump_issue) begin
            if (dump_last)
              issue_done <= 1'b1;
            else
              cur_addr <= cur_addr + 1'b1;
          end
          if (dump_done) begin
            busy  <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* logic/cmd_regs.sv */
`timescale 1ns/1ps

module cmd_regs (
  input  logic                                clk,
  input  logic                                rst,
  input  source_pkg::avs_req_t                avs,
  output logic [source_pkg::CSR_W-1:0]        readdata,
  output source_pkg::cmd_t                    cmd,
  input  logic                                cmd_accept,
  input  logic [source_pkg::BYTE_W-1:0]       rd_byte,
  input  logic                                rd_byte_load,
  input  logic                                busy,
  input  source_pkg::seq_state_e              seq_state,
  input  logic [source_pkg::RAM_ADDR_W-1:0]   cur_addr,
  input  logic [source_pkg::CNT_W-1:0]        beat_count,
  output logic                                clear_cnt,
  input  logic                                dma_ack,
  output logic                                dma_req
);
  import source_pkg::*;

  ctrl_word_u        ctrl;
  logic [CSR_W-1:0]  dma_ctrl;
  logic [BYTE_W-1:0] stat_byte;  // last byte returned by a read command
  logic              wr_en;
  logic [CSR_W-1:0]  stat_word;
  logic [CSR_W-1:0]  dbg_word;

  assign wr_en = avs.chipselect && !avs.write_n;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrl.raw <= '0;
    end else if (wr_en && avs.address == REG_CTRL) begin
      ctrl.raw <= avs.writedata;  // software write beats the hw clears
    end else begin
      if (cmd_accept)
        ctrl.fields.valid <= 1'b0;
      if (ctrl.fields.clear_cnt)
        ctrl.fields.clear_cnt <= 1'b0;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dma_ctrl <= '0;
    end else if (wr_en && avs.address == REG_DMA) begin
      dma_ctrl <= avs.writedata;
    end else if (dma_ack) begin
      dma_ctrl[0] <= 1'b0;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      stat_byte <= '0;
    else if (rd_byte_load)
      stat_byte <= rd_byte;
  end

  // command view of CTRL
  assign cmd.valid    = ctrl.fields.valid;
  assign cmd.cmd_type = ctrl.fields.cmd_type;
  assign cmd.addr     = ctrl.fields.addr;
  assign cmd.data     = ctrl.fields.data;

  assign clear_cnt = ctrl.fields.clear_cnt;  // counter held at zero this cycle
  assign dma_req   = dma_ctrl[0];

  assign stat_word = {16'h0000, stat_byte, 7'h00, busy};
  assign dbg_word  = {2'b00, seq_state, cur_addr, beat_count};

  always_comb begin
    case (avs.address)
      REG_CTRL: readdata = ctrl.raw;
      REG_STAT: readdata = stat_word;
      REG_DMA:  readdata = dma_ctrl;
      REG_DBG:  readdata = dbg_word;
      default:  readdata = '0;
    endcase
  end

endmodule

/* logic/source_pkg.sv */
package source_pkg;

  // memory geometry
  localparam int RAM_ADDR_W = 12;
  localparam int RAM_DEPTH  = 4096;
  localparam int BYTE_W     = 8;

  // register port
  localparam int CSR_W      = 32;
  localparam int CSR_ADDR_W = 2;
  localparam int CNT_W      = 16;

  // dump buffer size, also the sequencer credit limit
  localparam int DUMP_FIFO_DEPTH = 4;
  localparam int DUMP_PTR_W      = $clog2(DUMP_FIFO_DEPTH);

  localparam logic [CSR_ADDR_W-1:0] REG_CTRL = 2'd0;
  localparam logic [CSR_ADDR_W-1:0] REG_STAT = 2'd1;
  localparam logic [CSR_ADDR_W-1:0] REG_DMA  = 2'd2;
  localparam logic [CSR_ADDR_W-1:0] REG_DBG  = 2'd3;

  localparam logic [1:0] CMD_READ  = 2'b00;
  localparam logic [1:0] CMD_WRITE = 2'b01;
  localparam logic [1:0] CMD_DUMP  = 2'b10;
  localparam logic [1:0] CMD_RSVD  = 2'b11;

  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    READ_WAIT = 2'd1,
    DUMP      = 2'd2
  } seq_state_e;

  // CTRL register seen as command fields
  typedef struct packed {
    logic                  clear_cnt;  // bit 31, self clearing
    logic [6:0]            rsvd_hi;
    logic [BYTE_W-1:0]     data;
    logic [RAM_ADDR_W-1:0] addr;
    logic                  rsvd_lo;
    logic [1:0]            cmd_type;
    logic                  valid;      // bit 0, cleared on accept
  } ctrl_fields_t;

  typedef union packed {
    logic [CSR_W-1:0] raw;
    ctrl_fields_t     fields;
  } ctrl_word_u;

  typedef struct packed {
    logic                  chipselect;
    logic                  write_n;
    logic [CSR_ADDR_W-1:0] address;
    logic [CSR_W-1:0]      writedata;
  } avs_req_t;

  typedef struct packed {
    logic                  valid;
    logic [1:0]            cmd_type;
    logic [RAM_ADDR_W-1:0] addr;
    logic [BYTE_W-1:0]     data;
  } cmd_t;

  typedef struct packed {
    logic                  wr;
    logic                  rd;
    logic                  dump;  // tag, returned with the data
    logic                  last;  // tag, final dump address
    logic [RAM_ADDR_W-1:0] addr;
    logic [BYTE_W-1:0]     wdata;
  } ram_req_t;

  typedef struct packed {
    logic              valid;
    logic              dump;
    logic              last;
    logic [BYTE_W-1:0] data;
  } ram_rsp_t;

  typedef struct packed {
    logic [BYTE_W-1:0] tdata;
    logic              tvalid;
    logic              tlast;
  } axis_t;

endpackage
